//--- ppu_pkg.sv
package ppu_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] vadr_t;
	typedef logic [8:0]  dot_t;
	typedef logic [7:0]  line_t;
	typedef logic [1:0]  shade_t;
	typedef logic [3:0]  reg_adr_t;

	typedef enum logic [1:0] {
		HBLANK  = 2'd0,
		VBLANK  = 2'd1,
		OAMSRC  = 2'd2,
		PXTRANS = 2'd3
	} ppu_mode_t;

	typedef enum logic [2:0] {
		IDLE,
		TILE,
		LO_ADR,
		LO_DATA,
		HI_ADR,
		HI_DATA,
		BLOCK
	} fetch_state_t;

	localparam reg_adr_t REG_LCDC = 4'h0;
	localparam reg_adr_t REG_STAT = 4'h1;
	localparam reg_adr_t REG_SCY  = 4'h2;
	localparam reg_adr_t REG_SCX  = 4'h3;
	localparam reg_adr_t REG_LY   = 4'h4;
	localparam reg_adr_t REG_LYC  = 4'h5;
	localparam reg_adr_t REG_BGP  = 4'h7;

	localparam vadr_t MAP_BASE0          = 16'h9800;
	localparam vadr_t MAP_BASE1          = 16'h9c00;
	localparam vadr_t TILE_BASE_UNSIGNED = 16'h8000;
	localparam vadr_t TILE_BASE_SIGNED   = 16'h9000;

	localparam line_t VISIBLE_LINES = 8'd144;
	localparam dot_t  OAMSRC_DOTS   = 9'd80;
	localparam int    LINE_PIXELS   = 160;

	typedef struct packed {
		logic lcd_ena;  // bit 7.
		logic win_map;
		logic win_ena;
		logic bg_tiles; // set for unsigned tiles at 8000.
		logic bg_map;   // set for the map at 9c00.
		logic obj_size;
		logic obj_ena;
		logic bg_ena;   // bit 0.
	} lcdc_t;

	typedef struct packed {
		lcdc_t lcdc;
		byte_t scx;
		byte_t scy;
		byte_t bgp;
		byte_t lyc;
		logic  sel_lyc;
		logic  sel_mode2;
		logic  sel_mode1;
		logic  sel_mode0;
	} ppu_cfg_t;

	typedef struct packed {
		ppu_mode_t mode;
		logic      lyc_eq;
		line_t     ly;
	} ppu_status_t;

	typedef struct packed {
		logic   valid;
		shade_t shade;
	} px_out_t;

endpackage

//--- ppu_regs.sv
`timescale 1ns/1ns

module ppu_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  ppu_pkg::reg_adr_t     reg_adr,
	input  ppu_pkg::byte_t        reg_din,
	input  logic                  reg_read,
	input  logic                  reg_write,
	input  ppu_pkg::ppu_status_t  status,
	output ppu_pkg::byte_t        reg_dout,
	output ppu_pkg::ppu_cfg_t     cfg
);
	import ppu_pkg::*;

	logic  reg_write_d; // previous reg_write level.
	logic  reg_read_d;
	byte_t rd_val;

	always_comb begin
		case (reg_adr)
			REG_LCDC: rd_val = cfg.lcdc;
			REG_STAT: rd_val = {1'b1, cfg.sel_lyc, cfg.sel_mode2, cfg.sel_mode1,
			                    cfg.sel_mode0, status.lyc_eq, status.mode};
			REG_SCY:  rd_val = cfg.scy;
			REG_SCX:  rd_val = cfg.scx;
			REG_LY:   rd_val = status.ly;
			REG_LYC:  rd_val = cfg.lyc;
			REG_BGP:  rd_val = cfg.bgp;
			default:  rd_val = 8'hff; // unmapped offsets.
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_d <= 1'b0;
			reg_read_d  <= 1'b0;
			reg_dout    <= '0;
			cfg         <= '0;
		end else begin
			reg_write_d <= reg_write;
			reg_read_d  <= reg_read;

			if (reg_read && !reg_read_d)
				reg_dout <= rd_val; // held until the next read.

			// the write lands once the strobe has dropped.
			if (reg_write_d && !reg_write) begin
				case (reg_adr)
					REG_LCDC: cfg.lcdc <= lcdc_t'(reg_din);
					REG_STAT: begin
						cfg.sel_lyc   <= reg_din[6];
						cfg.sel_mode2 <= reg_din[5];
						cfg.sel_mode1 <= reg_din[4];
						cfg.sel_mode0 <= reg_din[3];
					end
					REG_SCY:  cfg.scy <= reg_din;
					REG_SCX:  cfg.scx <= reg_din;
					REG_LYC:  cfg.lyc <= reg_din;
					REG_BGP:  cfg.bgp <= reg_din;
					default:  ; // ly and unmapped offsets ignore writes.
				endcase
			end
		end
	end

endmodule

//--- ppu_timing.sv
`timescale 1ns/1ns

module ppu_timing #(
	parameter int DOTS_PER_LINE   = 456,
	parameter int LINES_PER_FRAME = 154
) (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::ppu_cfg_t    cfg,
	input  logic                 line_done,
	output ppu_pkg::ppu_status_t status,
	output logic                 line_start,
	output ppu_pkg::line_t       fetch_y,
	output logic                 irq_vblank,
	output logic                 irq_stat
);
	import ppu_pkg::*;

	localparam dot_t  LAST_DOT  = dot_t'(DOTS_PER_LINE - 1);
	localparam line_t LAST_LINE = line_t'(LINES_PER_FRAME - 1);

	dot_t        dot, dot_nxt;     // 0 .. 455.
	line_t       iline, iline_nxt; // internal line that runs the full last line.
	ppu_status_t status_nxt;
	logic        stat_sig, stat_sig_d;

	always_comb begin
		dot_nxt    = dot + 1'b1;
		iline_nxt  = iline;
		status_nxt = status;

		if (dot == LAST_DOT) begin
			dot_nxt       = '0;
			iline_nxt     = (iline == LAST_LINE) ? '0 : iline + 1'b1;
			status_nxt.ly = iline_nxt;
		end else if (iline == LAST_LINE && dot == dot_t'(7)) begin
			status_nxt.ly = '0; // ly wraps early from dot 8 on.
		end

		if (iline_nxt >= VISIBLE_LINES)
			status_nxt.mode = VBLANK;
		else if (dot_nxt < OAMSRC_DOTS)
			status_nxt.mode = OAMSRC;
		else if (dot_nxt == OAMSRC_DOTS)
			status_nxt.mode = PXTRANS;
		else if (line_done)
			status_nxt.mode = HBLANK; // mode 3 length follows the pixel FIFO.

		status_nxt.lyc_eq = (status_nxt.ly == cfg.lyc);

		if (!cfg.lcdc.lcd_ena) begin
			dot_nxt    = '0;
			iline_nxt  = '0;
			status_nxt = '0;
		end
	end

	assign stat_sig = cfg.lcdc.lcd_ena &&
	                  ((status.lyc_eq && cfg.sel_lyc) ||
	                   (status.mode == HBLANK && cfg.sel_mode0) ||
	                   (status.mode == VBLANK && (cfg.sel_mode1 || cfg.sel_mode2)) ||
	                   (status.mode == OAMSRC && cfg.sel_mode2));

	assign irq_vblank = cfg.lcdc.lcd_ena && dot == '0 && iline == VISIBLE_LINES;
	assign fetch_y    = iline + cfg.scy;

	always_ff @(posedge clk) begin
		if (reset) begin
			dot        <= '0;
			iline      <= '0;
			status     <= '0;
			line_start <= 1'b0;
			stat_sig_d <= 1'b0;
			irq_stat   <= 1'b0;
		end else begin
			dot        <= dot_nxt;
			iline      <= iline_nxt;
			status     <= status_nxt;
			line_start <= status_nxt.mode == PXTRANS && status.mode != PXTRANS;
			stat_sig_d <= stat_sig;
			irq_stat   <= stat_sig && !stat_sig_d; // rising edge only.
		end
	end

endmodule

//--- ppu_bg_fetch.sv
`timescale 1ns/1ns

module ppu_bg_fetch (
	input  logic               clk,
	input  logic               reset,
	input  ppu_pkg::ppu_cfg_t  cfg,
	input  logic               line_start,
	input  ppu_pkg::ppu_mode_t mode,
	input  ppu_pkg::line_t     fetch_y,
	input  logic               fifo_room,
	input  ppu_pkg::byte_t     mem_data,
	output ppu_pkg::vadr_t     mem_adr,
	output logic               mem_read,
	output logic               push,
	output ppu_pkg::byte_t     push_lo,
	output ppu_pkg::byte_t     push_hi
);
	import ppu_pkg::*;

	fetch_state_t state;
	logic [4:0]   col;      // map column that wraps at 32.
	byte_t        tile;
	byte_t        data_lo;
	byte_t        data_hi;
	logic         active;
	vadr_t        map_adr;
	vadr_t        tile_adr;
	vadr_t        row_adr;

	// the line start cycle only loads the column.
	assign active = (mode == PXTRANS) && !line_start;

	always_comb begin
		map_adr = (cfg.lcdc.bg_map ? MAP_BASE1 : MAP_BASE0) | vadr_t'({fetch_y[7:3], col});

		if (cfg.lcdc.bg_tiles)
			tile_adr = TILE_BASE_UNSIGNED + vadr_t'({tile, 4'b0000});
		else
			tile_adr = TILE_BASE_SIGNED + vadr_t'({{4{tile[7]}}, tile, 4'b0000});

		row_adr = tile_adr | vadr_t'({fetch_y[2:0], 1'b0}); // two bytes per tile row.

		case (state)
			LO_ADR:  mem_adr = row_adr;
			HI_ADR:  mem_adr = row_adr | 16'h0001;
			default: mem_adr = map_adr;
		endcase
	end

	assign mem_read = active && (state == IDLE || state == LO_ADR || state == HI_ADR);
	assign push     = active && state == BLOCK && fifo_room;
	assign push_lo  = data_lo;
	assign push_hi  = data_hi;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			col   <= '0;
		end else if (line_start) begin
			state <= IDLE;
			col   <= cfg.scx[7:3];
		end else if (mode != PXTRANS) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    state <= TILE;
				TILE:    state <= LO_ADR;
				LO_ADR:  state <= LO_DATA;
				LO_DATA: state <= HI_ADR;
				HI_ADR:  state <= HI_DATA;
				HI_DATA: state <= BLOCK;
				BLOCK: begin
					if (fifo_room) begin // back-pressure from the FIFO.
						state <= IDLE;
						col   <= col + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// memory answers one cycle after the address.
	always_ff @(posedge clk) begin
		if (state == TILE)
			tile <= mem_data;
		if (state == LO_DATA)
			data_lo <= mem_data;
		if (state == HI_DATA)
			data_hi <= mem_data;
	end

endmodule

//--- ppu_px_fifo.sv
`timescale 1ns/1ns

module ppu_px_fifo (
	input  logic              clk,
	input  logic              reset,
	input  ppu_pkg::ppu_cfg_t cfg,
	input  logic              line_start,
	input  logic              push,
	input  ppu_pkg::byte_t    push_lo,
	input  ppu_pkg::byte_t    push_hi,
	output logic              fifo_room,
	output logic              line_done,
	output ppu_pkg::px_out_t  px
);
	import ppu_pkg::*;

	logic [15:0] plane0, plane1; // colour bits with the next pixel at bit 15.
	logic [15:0] keep;
	logic [4:0]  len;            // 0 .. 16 pixels held.
	logic [2:0]  drop;           // fine scroll pixels left to discard.
	logic [7:0]  px_cnt;
	logic        active;
	logic        pop;
	shade_t      color;

	assign fifo_room = len <= 5'd8;
	assign pop       = active && cfg.lcdc.lcd_ena && len > 5'd8;
	assign keep      = ~(16'hffff >> len);
	assign color     = {plane1[15], plane0[15]};

	always_ff @(posedge clk) begin
		if (reset) begin
			len       <= '0;
			drop      <= '0;
			px_cnt    <= '0;
			active    <= 1'b0;
			line_done <= 1'b0;
			px        <= '0;
		end else begin
			line_done <= 1'b0;
			px.valid  <= 1'b0;
			px.shade  <= cfg.bgp[{color, 1'b0} +: 2];

			if (!cfg.lcdc.lcd_ena) begin
				active <= 1'b0;
				len    <= '0;
			end else if (line_start) begin
				active <= 1'b1;
				len    <= '0;
				drop   <= cfg.scx[2:0];
				px_cnt <= '0;
			end else if (push) begin
				len <= len + 5'd8;
			end else if (pop) begin
				len <= len - 1'b1;
				if (drop != '0) begin
					drop <= drop - 1'b1;
				end else begin
					px.valid <= 1'b1;
					px_cnt   <= px_cnt + 1'b1;
					if (px_cnt == 8'(LINE_PIXELS - 1)) begin
						line_done <= 1'b1;
						active    <= 1'b0;
					end
				end
			end
		end
	end

	// a push lands right behind the pixels still queued.
	always_ff @(posedge clk) begin
		if (push) begin
			plane0 <= (plane0 & keep) | ({push_lo, 8'h00} >> len);
			plane1 <= (plane1 & keep) | ({push_hi, 8'h00} >> len);
		end else if (pop) begin
			plane0 <= {plane0[14:0], 1'b0};
			plane1 <= {plane1[14:0], 1'b0};
		end
	end

endmodule

//--- ppu_top.sv
`timescale 1ns/1ns

module ppu_top #(
	parameter int DOTS_PER_LINE   = 456,
	parameter int LINES_PER_FRAME = 154
) (
	input  logic              clk,
	input  logic              reset,
	input  ppu_pkg::reg_adr_t reg_adr,
	input  ppu_pkg::byte_t    reg_din,
	input  logic              reg_read,
	input  logic              reg_write,
	output ppu_pkg::byte_t    reg_dout,
	output logic              irq_vblank,
	output logic              irq_stat,
	output ppu_pkg::vadr_t    mem_adr,
	output logic              mem_read,
	input  ppu_pkg::byte_t    mem_data,
	output ppu_pkg::px_out_t  px
);
	import ppu_pkg::*;

	ppu_cfg_t    cfg;
	ppu_status_t status;
	logic        line_start;
	line_t       fetch_y;
	logic        line_done;
	logic        fifo_room;
	logic        push;
	byte_t       push_lo;
	byte_t       push_hi;

	ppu_regs i_regs (
		.clk, .reset, .reg_adr, .reg_din, .reg_read, .reg_write,
		.status, .reg_dout, .cfg
	);

	ppu_timing #(
		.DOTS_PER_LINE   (DOTS_PER_LINE),
		.LINES_PER_FRAME (LINES_PER_FRAME)
	) i_timing (
		.clk, .reset, .cfg, .line_done,
		.status, .line_start, .fetch_y, .irq_vblank, .irq_stat
	);

	ppu_bg_fetch i_bg_fetch (
		.clk, .reset, .cfg, .line_start, .mode(status.mode), .fetch_y, .fifo_room,
		.mem_data, .mem_adr, .mem_read, .push, .push_lo, .push_hi
	);

	ppu_px_fifo i_px_fifo (
		.clk, .reset, .cfg, .line_start, .push, .push_lo, .push_hi,
		.fifo_room, .line_done, .px
	);

endmodule

//--- tb_ppu_assertions.sv
`timescale 1ns/1ns

module tb_ppu_assertions (
	input logic               clk,
	input logic               reset,
	input logic               irq_vblank,
	input logic               mem_read,
	input logic               px_valid,
	input ppu_pkg::ppu_mode_t mode
);
	import ppu_pkg::*;

	vblank_single: assert property (@(posedge clk) disable iff (reset)
		irq_vblank |=> !irq_vblank)
		else $error("irq_vblank high for two cycles in a row");

	fetch_in_mode3: assert property (@(posedge clk) disable iff (reset)
		mem_read |-> mode == PXTRANS) // fetcher only runs in pixel transfer.
		else $error("mem_read high outside mode 3");

	pixel_in_mode3: assert property (@(posedge clk) disable iff (reset)
		px_valid |-> mode == PXTRANS)
		else $error("px.valid high outside mode 3");

endmodule

bind ppu_top tb_ppu_assertions i_assertions (
	.clk        (clk),
	.reset      (reset),
	.irq_vblank (irq_vblank),
	.mem_read   (mem_read),
	.px_valid   (px.valid),
	.mode       (status.mode)
);

//--- tb_ppu.sv
`timescale 1ns/1ns

module tb_ppu;
	import ppu_pkg::*;

	typedef struct packed {
		byte_t lcdc;      // control bits that get lcd enable added when applied.
		byte_t scx;
		byte_t scy;
		byte_t bgp;
		byte_t lyc;
		vadr_t map_base;  // expected map for lcdc bit 3.
		vadr_t tile_base; // expected tile data base for lcdc bit 4.
	} row_t;

	localparam int NUM_ROWS     = 4;
	localparam int FRAME_CYCLES = 456 * 154;
	localparam int FRAME_PIXELS = 144 * 160;

	logic        clk = 1'b0;
	logic        reset;
	reg_adr_t    reg_adr;
	byte_t       reg_din;
	logic        reg_read;
	logic        reg_write;
	byte_t       reg_dout;
	logic        irq_vblank;
	logic        irq_stat;
	vadr_t       mem_adr;
	logic        mem_read;
	byte_t       mem_data;
	px_out_t     px;
	row_t        table_rows [NUM_ROWS];
	row_t        cur;
	logic        lcd_on = 1'b0;
	int          pix_count;
	int          stat_count;
	logic [31:0] lfsr = 32'h2fe7;
	vadr_t       adr_q;

	ppu_top i_dut (
		.clk, .reset, .reg_adr, .reg_din, .reg_read, .reg_write, .reg_dout,
		.irq_vblank, .irq_stat, .mem_adr, .mem_read, .mem_data, .px
	);

	always #10 clk = ~clk;

	function automatic byte_t mem_byte(input vadr_t adr);
		return byte_t'(adr[7:0] * 37 + adr[15:8]);
	endfunction

	function automatic shade_t expected_shade(input int x, input int y);
		int    bx;
		int    by;
		int    row_adr;
		byte_t tile_num;
		byte_t lo;
		byte_t hi;
		int    color;
		bx       = (x + cur.scx) % 256;
		by       = (y + cur.scy) % 256;
		tile_num = mem_byte(vadr_t'(cur.map_base + (by / 8) * 32 + bx / 8));
		if (cur.tile_base == TILE_BASE_SIGNED)
			row_adr = int'(cur.tile_base) + int'($signed(tile_num)) * 16; // -128 .. 127.
		else
			row_adr = int'(cur.tile_base) + int'(tile_num) * 16;
		row_adr = row_adr + 2 * (by % 8);
		lo      = mem_byte(vadr_t'(row_adr));
		hi      = mem_byte(vadr_t'(row_adr + 1));
		color   = {hi[7 - bx % 8], lo[7 - bx % 8]};
		return shade_t'(cur.bgp >> (2 * color));
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
	endfunction

	task automatic take_bits(input int n, output byte_t val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[6:0], lfsr[0]};
		end
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected)
			stop_with_failure($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
			                            $time, name, actual, expected));
	endtask

	task automatic write_register(input reg_adr_t adr, input byte_t data);
		@(posedge clk);
		#2;
		reg_adr   = adr;
		reg_din   = data;
		reg_write = 1'b1;
		@(posedge clk);
		#2;
		reg_write = 1'b0;
		@(posedge clk); // write lands on this edge.
		#2;
	endtask

	task automatic expect_register(input string name, input reg_adr_t adr, input byte_t exp);
		@(posedge clk);
		#2;
		reg_adr  = adr;
		reg_read = 1'b1;
		@(posedge clk);
		#2;
		reg_read = 1'b0;
		check_value(name, reg_dout, exp);
	endtask

	task automatic wait_for_irq(input logic vblank);
		do
			@(negedge clk);
		while (vblank ? !irq_vblank : !irq_stat);
	endtask

	task automatic run_row(input row_t row);
		cur = row;
		write_register(REG_SCX, row.scx);
		write_register(REG_SCY, row.scy);
		write_register(REG_BGP, row.bgp);
		write_register(REG_LYC, row.lyc);
		write_register(REG_STAT, 8'h3f); // mode and coincidence bits are read-only.
		expect_register("stat selects", REG_STAT, 8'hb8);
		write_register(REG_STAT, 8'h40); // lyc select only.
		write_register(REG_LY, 8'h55);   // read-only.
		expect_register("scx", REG_SCX, row.scx);
		expect_register("scy", REG_SCY, row.scy);
		expect_register("bgp", REG_BGP, row.bgp);
		expect_register("lyc", REG_LYC, row.lyc);
		expect_register("stat", REG_STAT, 8'hc0);
		expect_register("ly", REG_LY, 8'h00);
		expect_register("unmapped reg 6", 4'h6, 8'hff);
		expect_register("unmapped reg f", 4'hf, 8'hff);
		pix_count  = 0;
		stat_count = 0;
		lcd_on     = 1'b1;
		write_register(REG_LCDC, row.lcdc | 8'h80);
		expect_register("lcdc", REG_LCDC, row.lcdc | 8'h80);
		wait_for_irq(1'b0);
		expect_register("stat at lyc", REG_STAT, 8'hc4 | 8'(2)); // coincidence in mode 2.
		expect_register("ly at lyc", REG_LY, row.lyc);
		wait_for_irq(1'b1);
		expect_register("ly in vblank", REG_LY, 8'd144);
		expect_register("stat in vblank", REG_STAT, 8'hc1);
		repeat (9 * 456 + 8) @(posedge clk); // into line 153, past dot 8.
		expect_register("ly late in line 153", REG_LY, 8'h00);
		expect_register("stat late in line 153", REG_STAT, 8'hc1);
		wait_for_irq(1'b1); // one more whole frame.
		write_register(REG_LCDC, 8'h00);
		lcd_on = 1'b0;
	endtask

	// registered video memory that only answers a read.
	always @(negedge clk)
		adr_q <= mem_read ? mem_adr : 16'h0000;

	always @(posedge clk) begin
		#2;
		mem_data <= mem_byte(adr_q);
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (!lcd_on && (px.valid || mem_read || irq_vblank || irq_stat))
				stop_with_failure("pixels, memory reads or interrupts appeared with the LCD off");
			if (px.valid) begin
				check_value("px.shade", px.shade,
				            expected_shade(pix_count % 160, pix_count / 160));
				pix_count++;
			end
			if (irq_stat)
				stat_count++;
			if (irq_vblank) begin
				check_value("pixels per frame", pix_count, FRAME_PIXELS);
				check_value("irq_stat pulses per frame", stat_count, 1);
				pix_count  = 0;
				stat_count = 0;
			end
		end
	end

	// each row and the final lcd off check get two frames.
	initial begin
		#((NUM_ROWS + 1) * 2 * FRAME_CYCLES * 20);
		stop_with_failure("watchdog timeout, the test did not finish in time");
	end

	initial begin
		byte_t rnd;
		reset     = 1'b1;
		reg_adr   = '0;
		reg_din   = '0;
		reg_read  = 1'b0;
		reg_write = 1'b0;
		mem_data  = '0;
		table_rows[0] = '{8'h11, 8'h00, 8'h00, 8'he4, 8'd10, 16'h9800, 16'h8000};
		table_rows[1] = '{8'h09, 8'h05, 8'h13, 8'h1b, 8'd77, 16'h9c00, 16'h9000};
		table_rows[2] = '{8'h19, 8'hfb, 8'hf0, 8'h9c, 8'd143, 16'h9c00, 16'h8000};
		take_bits(2, rnd);
		table_rows[3].lcdc      = {3'b000, rnd[1], rnd[0], 3'b001};
		table_rows[3].map_base  = rnd[0] ? MAP_BASE1 : MAP_BASE0;
		table_rows[3].tile_base = rnd[1] ? TILE_BASE_UNSIGNED : TILE_BASE_SIGNED;
		take_bits(8, table_rows[3].scx);
		take_bits(8, table_rows[3].scy);
		take_bits(8, table_rows[3].bgp);
		take_bits(8, rnd);
		table_rows[3].lyc = byte_t'(1 + rnd % 143);
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(table_rows[i]);
		repeat (FRAME_CYCLES) @(posedge clk);
		expect_register("ly with lcd off", REG_LY, 8'h00);
		expect_register("stat with lcd off", REG_STAT, 8'hc0);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- filelist.f
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
ppu_bg_fetch.sv
ppu_px_fifo.sv
ppu_top.sv
tb_ppu_assertions.sv
tb_ppu.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status carries the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_ppu -f filelist.f -o tb_ppu \
	&& ./obj_dir/tb_ppu \
	|| exit 1
